// File: sources.f
src/ex_pkg.sv
src/ex_operand_select.sv
src/ex_alu32.sv
src/ex_shifter.sv
src/ex_result_select.sv
src/ex_wb_latch.sv
src/execute_stage.sv
verif/execute_stage_assertions.sv
verif/execute_stage_tb.sv

// File: Makefile
TOOL     = verilator
FLAGS    = --binary --timing --assert -j 0
TOP      = execute_stage_tb
FILELIST = sources.f
LOG      = sim.log

.PHONY: sim clean

sim:
	$(TOOL) $(FLAGS) --top-module $(TOP) -f $(FILELIST)
	./obj_dir/V$(TOP) > $(LOG) 2>&1; cat $(LOG)
	@if grep -q "Done: errors found" $(LOG); then exit 1; fi
	@grep -q "Done: no errors" $(LOG)

clean:
	rm -rf obj_dir $(LOG)

// File: verif/execute_stage_tb.sv
module execute_stage_tb;
  import ex_pkg::*;

  localparam int clk_period      = 20;
  // alu, shift, cmpxchg, cmps and repne, stall, dependency
  localparam int num_test_cycles = 3 * 8 * 4 + 3 * 3 * 6 + 2 + (2 * 2 + 4) + 5 + 2 * 16 * 3;
  localparam int timeout         = (8 + num_test_cycles) * clk_period + 1000;

  logic      clk;
  logic      rst_n;
  logic      ex_v;
  alu_op_e   ex_alu_op;
  shift_op_e ex_shift_op;
  size_e     ex_size;
  unit_sel_e ex_unit_sel;
  logic      ex_ld_gpr1;
  logic      ex_ld_gpr2;
  logic      ex_ld_gpr3;
  logic      ex_dcache_write;
  logic      ex_is_cmpxchg;
  logic      ex_is_cmps_first;
  logic      ex_is_cmps_second;
  logic      ex_repne_steady;
  logic      ex_repne;
  word_t     ex_a;
  word_t     ex_b;
  word_t     ex_c;
  reg_idx_t  ex_dr1;
  reg_idx_t  ex_dr2;
  reg_idx_t  ex_dr3;
  flags_t    flags_fwd;
  word_t     count_fwd;
  logic      wb_stall;
  logic      wb_repne_terminate;
  logic      wb_ld_latches;
  logic      wb_v;
  logic      wb_ld_gpr1;
  logic      wb_ld_gpr2;
  logic      wb_ld_gpr3;
  logic      wb_dcache_write;
  word_t     wb_result_a;
  word_t     wb_result_b;
  word_t     wb_result_c;
  flags_t    wb_flags;
  reg_idx_t  wb_dr1;
  reg_idx_t  wb_dr2;
  reg_idx_t  wb_dr3;
  logic      dep_v_gpr1;
  logic      dep_v_gpr2;
  logic      dep_v_gpr3;
  logic      dep_v_dcache_write;

  int          checks;
  int          errors;
  logic [31:0] rng_state;

  execute_stage uut (.*);

  initial begin
    clk = 1'b0;
    forever #(clk_period / 2) clk = ~clk;
  end

  // watchdog
  initial begin
    #(timeout);
    $display("watchdog expired, the tests did not finish in time");
    $display("Done: errors found");
    $finish;
  end

  function automatic logic [31:0] xorshift32();
    logic [31:0] x;
    x = rng_state;
    x = x ^ (x << 13);
    x = x ^ (x >> 17);
    x = x ^ (x << 5);
    rng_state = x;
    return x;
  endfunction

  function automatic int width_of(size_e s);
    if (s == size_8) return 8;
    if (s == size_16) return 16;
    return 32;
  endfunction

  function automatic word_t low_mask(int n);
    return (n == 32) ? 32'hffff_ffff : ((32'd1 << n) - 32'd1);
  endfunction

  function automatic logic top_bit(word_t v, int n);
    return v[n-1];
  endfunction

  // flags that follow the result value
  function automatic flags_t result_flags(flags_t f, word_t res, int n, logic cf, logic of);
    flags_t r;
    r          = f;
    r[flag_cf] = cf;
    r[flag_of] = of;
    r[flag_zf] = (res == 32'd0);
    r[flag_sf] = top_bit(res, n);
    r[flag_pf] = ~^res[7:0];
    return r;
  endfunction

  task automatic alu_model(input alu_op_e op, input size_e s, input word_t a, input word_t b,
                           input flags_t fin, output word_t res, output flags_t fl);
    int          n;
    word_t       m;
    logic [63:0] ua;
    logic [63:0] ub;
    logic [63:0] full;
    logic        cf;
    logic        of;
    n    = width_of(s);
    m    = low_mask(n);
    ua   = {32'd0, a & m};
    ub   = {32'd0, b & m};
    full = 64'd0;
    cf   = 1'b0;
    of   = 1'b0;
    case (op)
      alu_add:    full = ua + ub;
      alu_sub:    full = ua - ub;
      alu_cmp:    full = ua - ub;
      alu_and:    full = ua & ub;
      alu_or:     full = ua | ub;
      alu_xor:    full = ua ^ ub;
      alu_not:    full = ~ua;
      default:    full = ub;
    endcase
    res = full[31:0] & m;
    if (op == alu_add) begin
      cf = full[n];
      of = (top_bit(a, n) == top_bit(b, n)) && (top_bit(res, n) != top_bit(a, n));
    end else if (op == alu_sub || op == alu_cmp) begin
      cf = (ua < ub);
      of = (top_bit(a, n) != top_bit(b, n)) && (top_bit(res, n) != top_bit(a, n));
    end
    fl = (op == alu_not) ? fin : result_flags(fin, res, n, cf, of);
  endtask

  task automatic shift_model(input shift_op_e op, input size_e s, input word_t value,
                             input word_t amount, input flags_t fin,
                             output word_t res, output flags_t fl);
    int         n;
    int         amt;
    word_t      m;
    word_t      v;
    logic [31:0] sx;
    logic       cf;
    logic       of;
    n   = width_of(s);
    m   = low_mask(n);
    v   = value & m;
    amt = int'(amount[4:0]);
    sx  = (n == 32) ? v : (top_bit(v, n) ? (v | ~m) : v);
    if (op == sh_none || amt == 0) begin
      res = value;
      fl  = fin;
    end else begin
      case (op)
        sh_shl: begin
          res = (v << amt) & m;
          cf  = (amt <= n) ? v[n-amt] : 1'b0;
          of  = top_bit(res, n) ^ cf;
        end
        sh_shr: begin
          res = v >> amt;
          cf  = v[amt-1];
          of  = top_bit(v, n);
        end
        default: begin
          res = word_t'($signed(sx) >>> amt) & m;
          cf  = sx[amt-1];
          of  = 1'b0;
        end
      endcase
      fl = result_flags(fin, res, n, cf, of);
    end
  endtask

  task automatic check(input string what, input logic [31:0] got, input logic [31:0] exp);
    checks++;
    assert (got === exp) else begin
      $display("** Error at time %0t: %s is %h, expected %h", $time, what, got, exp);
      errors++;
    end
  endtask

  task automatic report_test(input string name, input int errors_before);
    $display("test %s finished, %0d errors", name, errors - errors_before);
  endtask

  task automatic next_cycle();
    @(posedge clk);
    #1;
  endtask

  task automatic default_inputs();
    ex_v               = 1'b1;
    ex_alu_op          = alu_add;
    ex_shift_op        = sh_none;
    ex_size            = size_32;
    ex_unit_sel        = unit_alu;
    ex_ld_gpr1         = 1'b1;
    ex_ld_gpr2         = 1'b0;
    ex_ld_gpr3         = 1'b0;
    ex_dcache_write    = 1'b0;
    ex_is_cmpxchg      = 1'b0;
    ex_is_cmps_first   = 1'b0;
    ex_is_cmps_second  = 1'b0;
    ex_repne_steady    = 1'b0;
    ex_repne           = 1'b0;
    ex_a               = '0;
    ex_b               = '0;
    ex_c               = '0;
    ex_dr1             = 3'd1;
    ex_dr2             = 3'd2;
    ex_dr3             = 3'd3;
    flags_fwd          = '0;
    count_fwd          = '0;
    wb_stall           = 1'b0;
    wb_repne_terminate = 1'b0;
  endtask

  task automatic alu_ops();
    int     e0;
    word_t  res;
    flags_t fl;
    e0 = errors;
    for (int si = 0; si < 3; si++) begin
      for (int op = 0; op < 8; op++) begin
        for (int rep = 0; rep < 4; rep++) begin
          default_inputs();
          ex_size   = size_e'(si);
          ex_alu_op = alu_op_e'(op);
          ex_a      = xorshift32();
          // last pass gives equal operands for a zero result
          ex_b      = (rep == 3) ? ex_a : xorshift32();
          flags_fwd = xorshift32();
          alu_model(ex_alu_op, ex_size, ex_a, ex_b, flags_fwd, res, fl);
          next_cycle();
          check($sformatf("alu op %0d size %0d result", op, si), wb_result_a, res);
          check($sformatf("alu op %0d size %0d flags", op, si), wb_flags, fl);
          check("alu wb_v", wb_v, 1'b1);
        end
      end
    end
    report_test("alu", e0);
  endtask

  task automatic shift_ops();
    int     e0;
    word_t  res;
    flags_t fl;
    word_t  amounts [6];
    e0 = errors;
    for (int si = 0; si < 3; si++) begin
      for (int op = 1; op < 4; op++) begin
        amounts = '{32'd0, 32'd1, xorshift32() % 32, 32'd31, 32'd37, 32'hffff_ffe0};
        for (int k = 0; k < 6; k++) begin
          default_inputs();
          ex_size     = size_e'(si);
          ex_shift_op = shift_op_e'(op);
          ex_unit_sel = unit_shift;
          ex_a        = xorshift32();
          ex_b        = amounts[k];
          flags_fwd   = xorshift32();
          shift_model(ex_shift_op, ex_size, ex_a, ex_b, flags_fwd, res, fl);
          next_cycle();
          check($sformatf("shift op %0d size %0d amt %0d result", op, si, ex_b), wb_result_a, res);
          check($sformatf("shift op %0d size %0d amt %0d flags", op, si, ex_b), wb_flags, fl);
        end
      end
    end
    report_test("shift", e0);
  endtask

  task automatic cmpxchg_decision();
    int    e0;
    word_t dest;
    word_t src;
    e0 = errors;
    for (int eq = 1; eq >= 0; eq--) begin
      default_inputs();
      dest            = xorshift32();
      src             = xorshift32();
      ex_is_cmpxchg   = 1'b1;
      ex_ld_gpr2      = 1'b1;
      ex_dcache_write = 1'b1;
      ex_a            = dest;
      ex_b            = src;
      ex_c            = eq ? dest : dest ^ 32'h10;
      next_cycle();
      check("cmpxchg zf", wb_flags[flag_zf], eq);
      check("cmpxchg ld_gpr1", wb_ld_gpr1, eq);
      check("cmpxchg ld_gpr2", wb_ld_gpr2, !eq);
      check("cmpxchg dcache_write", wb_dcache_write, eq);
      check("cmpxchg result b", wb_result_b, dest);
      if (eq) begin
        check("cmpxchg result a", wb_result_a, src);
      end
    end
    report_test("cmpxchg", e0);
  endtask

  task automatic cmps_repne_loop();
    int     e0;
    word_t  first;
    word_t  res;
    flags_t fl;
    word_t  n;
    e0 = errors;
    for (int eq = 0; eq < 2; eq++) begin
      default_inputs();
      first            = xorshift32();
      ex_alu_op        = alu_cmp;
      ex_is_cmps_first = 1'b1;
      ex_a             = first;
      ex_c             = xorshift32();
      next_cycle();
      check("cmps first result c", wb_result_c, ex_c);
      default_inputs();
      ex_alu_op         = alu_cmp;
      ex_is_cmps_second = 1'b1;
      ex_a              = eq ? first : xorshift32();
      ex_b              = xorshift32();
      alu_model(alu_cmp, size_32, ex_a, first, flags_fwd, res, fl);
      next_cycle();
      check("cmps second flags", wb_flags, fl);
    end
    // loop entry uses count_fwd, later iterations the running count
    n = 32'd5 + (xorshift32() % 100);
    for (int k = 0; k < 4; k++) begin
      default_inputs();
      ex_repne        = 1'b1;
      ex_repne_steady = (k != 0);
      count_fwd       = (k == 0) ? n : xorshift32();
      next_cycle();
      check($sformatf("repne iteration %0d result c", k), wb_result_c, n - k - 1);
    end
    report_test("cmps_repne", e0);
  endtask

  task automatic stall_and_terminate();
    int     e0;
    word_t  held_a;
    flags_t held_flags;
    e0 = errors;
    default_inputs();
    ex_a        = xorshift32();
    ex_unit_sel = unit_pass_a;
    next_cycle();
    held_a     = wb_result_a;
    held_flags = wb_flags;
    check("load before stall", held_a, ex_a);
    wb_stall = 1'b1;
    ex_a     = ~held_a;
    ex_v     = 1'b0;
    #1;
    check("wb_ld_latches while stalled", wb_ld_latches, 1'b0);
    for (int k = 0; k < 2; k++) begin
      next_cycle();
      check("held result a", wb_result_a, held_a);
      check("held flags", wb_flags, held_flags);
      check("held wb_v", wb_v, 1'b1);
    end
    wb_stall = 1'b0;
    ex_v     = 1'b1;
    #1;
    check("wb_ld_latches after stall", wb_ld_latches, 1'b1);
    next_cycle();
    check("result a after stall", wb_result_a, ~held_a);
    wb_repne_terminate = 1'b1;
    next_cycle();
    check("wb_v after terminate", wb_v, 1'b0);
    wb_repne_terminate = 1'b0;
    report_test("stall", e0);
  endtask

  task automatic dependency_bits();
    int   e0;
    logic eq;
    logic exp1;
    logic exp2;
    logic expd;
    e0 = errors;
    for (int v = 0; v < 2; v++) begin
      for (int en = 0; en < 16; en++) begin
        for (int mode = 0; mode < 3; mode++) begin
          default_inputs();
          ex_v            = v[0];
          ex_ld_gpr1      = en[0];
          ex_ld_gpr2      = en[1];
          ex_ld_gpr3      = en[2];
          ex_dcache_write = en[3];
          ex_is_cmpxchg   = (mode != 0);
          ex_a            = xorshift32();
          ex_c            = (mode == 1) ? ex_a : ~ex_a;
          ex_dr1          = reg_idx_t'(xorshift32());
          ex_dr2          = reg_idx_t'(xorshift32());
          ex_dr3          = reg_idx_t'(xorshift32());
          eq              = (mode == 1);
          exp1 = (mode == 0) ? en[0] : en[0] & eq;
          exp2 = (mode == 0) ? en[1] : !eq;
          expd = (mode == 0) ? en[3] : en[3] & eq;
          #1;
          check("dep_v_gpr1", dep_v_gpr1, v[0] & exp1);
          check("dep_v_gpr2", dep_v_gpr2, v[0] & exp2);
          check("dep_v_gpr3", dep_v_gpr3, v[0] & en[2]);
          check("dep_v_dcache_write", dep_v_dcache_write, v[0] & expd);
          next_cycle();
          // the same uop one cycle later in the stage register
          check("wb_v", wb_v, v[0]);
          check("wb_ld_gpr1", wb_ld_gpr1, exp1);
          check("wb_ld_gpr2", wb_ld_gpr2, exp2);
          check("wb_ld_gpr3", wb_ld_gpr3, en[2]);
          check("wb_dcache_write", wb_dcache_write, expd);
          check("wb_dr1", wb_dr1, ex_dr1);
          check("wb_dr2", wb_dr2, ex_dr2);
          check("wb_dr3", wb_dr3, ex_dr3);
        end
      end
    end
    report_test("dependency", e0);
  endtask

  initial begin
    checks    = 0;
    errors    = 0;
    rng_state = 32'h2d65;
    default_inputs();
    ex_v  = 1'b0;
    rst_n = 1'b0;
    repeat (8) @(posedge clk);
    #1;
    rst_n = 1'b1;
    check("wb_v after reset", wb_v, 1'b0);
    alu_ops();
    shift_ops();
    cmpxchg_decision();
    cmps_repne_loop();
    stall_and_terminate();
    dependency_bits();
    $display("checks run: %0d, errors: %0d", checks, errors);
    if (errors == 0) begin
      $display("Done: no errors");
    end else begin
      $display("Done: errors found");
    end
    $finish;
  end

endmodule

// File: verif/execute_stage_assertions.sv
module execute_stage_assertions (
  input logic             clk,
  input logic             rst_n,
  input logic             ex_v,
  input logic             wb_stall,
  input logic             wb_repne_terminate,
  input logic             wb_v,
  input logic             wb_ld_gpr1,
  input logic             wb_ld_gpr2,
  input logic             wb_ld_gpr3,
  input logic             wb_dcache_write,
  input ex_pkg::word_t    wb_result_a,
  input ex_pkg::word_t    wb_result_b,
  input ex_pkg::word_t    wb_result_c,
  input ex_pkg::flags_t   wb_flags,
  input logic             dep_v_gpr1,
  input logic             dep_v_gpr2,
  input logic             dep_v_gpr3,
  input logic             dep_v_dcache_write
);

  // reset leaves a bubble in the stage register
  reset_bubble: assert property (@(posedge clk) !rst_n |=> !wb_v)
    else $error("wb_v not low after reset");

  stall_hold: assert property (@(posedge clk) (rst_n && wb_stall) |=>
      ($stable(wb_v) && $stable(wb_result_a) && $stable(wb_result_b) &&
       $stable(wb_result_c) && $stable(wb_flags)))
    else $error("stage register changed while stalled");

  // dependency bits are the valid writes that reach writeback
  dep_matches_wb: assert property (@(posedge clk)
      (rst_n && !wb_stall && !wb_repne_terminate) |=>
      (((wb_v && wb_ld_gpr1) == $past(dep_v_gpr1)) &&
       ((wb_v && wb_ld_gpr2) == $past(dep_v_gpr2)) &&
       ((wb_v && wb_ld_gpr3) == $past(dep_v_gpr3)) &&
       ((wb_v && wb_dcache_write) == $past(dep_v_dcache_write))))
    else $error("dependency bits disagree with the loaded valid writes");

endmodule

bind ex_wb_latch execute_stage_assertions u_assertions (.*);

// File: src/execute_stage.sv
module execute_stage (
  input  logic              clk,
  input  logic              rst_n,
  input  logic              ex_v,
  input  ex_pkg::alu_op_e   ex_alu_op,
  input  ex_pkg::shift_op_e ex_shift_op,
  input  ex_pkg::size_e     ex_size,
  input  ex_pkg::unit_sel_e ex_unit_sel,
  input  logic              ex_ld_gpr1,
  input  logic              ex_ld_gpr2,
  input  logic              ex_ld_gpr3,
  input  logic              ex_dcache_write,
  input  logic              ex_is_cmpxchg,
  input  logic              ex_is_cmps_first,
  input  logic              ex_is_cmps_second,
  input  logic              ex_repne_steady,
  input  logic              ex_repne,
  input  ex_pkg::word_t     ex_a,
  input  ex_pkg::word_t     ex_b,
  input  ex_pkg::word_t     ex_c,
  input  ex_pkg::reg_idx_t  ex_dr1,
  input  ex_pkg::reg_idx_t  ex_dr2,
  input  ex_pkg::reg_idx_t  ex_dr3,
  input  ex_pkg::flags_t    flags_fwd,
  input  ex_pkg::word_t     count_fwd,
  input  logic              wb_stall,
  input  logic              wb_repne_terminate,
  output logic              wb_ld_latches,
  output logic              wb_v,
  output logic              wb_ld_gpr1,
  output logic              wb_ld_gpr2,
  output logic              wb_ld_gpr3,
  output logic              wb_dcache_write,
  output ex_pkg::word_t     wb_result_a,
  output ex_pkg::word_t     wb_result_b,
  output ex_pkg::word_t     wb_result_c,
  output ex_pkg::flags_t    wb_flags,
  output ex_pkg::reg_idx_t  wb_dr1,
  output ex_pkg::reg_idx_t  wb_dr2,
  output ex_pkg::reg_idx_t  wb_dr3,
  output logic              dep_v_gpr1,
  output logic              dep_v_gpr2,
  output logic              dep_v_gpr3,
  output logic              dep_v_dcache_write
);
  import ex_pkg::*;

  word_t   b_eff;
  word_t   count;
  word_t   alu_a;
  word_t   alu_b;
  word_t   alu_result;
  word_t   shift_result;
  word_t   result_a;
  word_t   result_b;
  word_t   result_c;
  flags_t  alu_flags;
  flags_t  shift_flags;
  flags_t  flags;
  alu_op_e alu_op;
  logic    is_shift;
  logic    ld_gpr1;
  logic    ld_gpr2;
  logic    dcache_write;

  assign is_shift = (ex_shift_op != sh_none);

  // cmpxchg forces accumulator minus destination through the alu
  always_comb begin
    if (ex_is_cmpxchg) begin
      alu_op = alu_cmp;
      alu_a  = ex_c;
      alu_b  = ex_a;
    end else begin
      alu_op = ex_alu_op;
      alu_a  = ex_a;
      alu_b  = b_eff;
    end
  end

  ex_operand_select u_operand_select (
    .clk            (clk),
    .rst_n          (rst_n),
    .ld             (wb_ld_latches),
    .ex_v           (ex_v),
    .is_cmps_first  (ex_is_cmps_first),
    .is_cmps_second (ex_is_cmps_second),
    .repne_steady   (ex_repne_steady),
    .repne          (ex_repne),
    .a              (ex_a),
    .b              (ex_b),
    .count_fwd      (count_fwd),
    .b_eff          (b_eff),
    .count          (count)
  );

  ex_alu32 u_alu32 (
    .op       (alu_op),
    .size     (ex_size),
    .a        (alu_a),
    .b        (alu_b),
    .flags_in (flags_fwd),
    .result   (alu_result),
    .flags    (alu_flags)
  );

  ex_shifter u_shifter (
    .op       (ex_shift_op),
    .size     (ex_size),
    .value    (ex_a),
    .amount   (b_eff),
    .flags_in (flags_fwd),
    .result   (shift_result),
    .flags    (shift_flags)
  );

  ex_result_select u_result_select (
    .unit_sel        (ex_unit_sel),
    .is_cmpxchg      (ex_is_cmpxchg),
    .is_shift        (is_shift),
    .repne           (ex_repne),
    .ld_gpr1_in      (ex_ld_gpr1),
    .ld_gpr2_in      (ex_ld_gpr2),
    .dcache_write_in (ex_dcache_write),
    .a               (ex_a),
    .b               (ex_b),
    .c               (ex_c),
    .count           (count),
    .alu_result      (alu_result),
    .shift_result    (shift_result),
    .alu_flags       (alu_flags),
    .shift_flags     (shift_flags),
    .flags_fwd       (flags_fwd),
    .result_a        (result_a),
    .result_b        (result_b),
    .result_c        (result_c),
    .flags           (flags),
    .ld_gpr1         (ld_gpr1),
    .ld_gpr2         (ld_gpr2),
    .dcache_write    (dcache_write)
  );

  ex_wb_latch u_wb_latch (
    .clk                (clk),
    .rst_n              (rst_n),
    .ex_v               (ex_v),
    .wb_stall           (wb_stall),
    .wb_repne_terminate (wb_repne_terminate),
    .ld_gpr1            (ld_gpr1),
    .ld_gpr2            (ld_gpr2),
    .ld_gpr3            (ex_ld_gpr3),
    .dcache_write       (dcache_write),
    .result_a           (result_a),
    .result_b           (result_b),
    .result_c           (result_c),
    .flags              (flags),
    .dr1                (ex_dr1),
    .dr2                (ex_dr2),
    .dr3                (ex_dr3),
    .wb_ld_latches      (wb_ld_latches),
    .wb_v               (wb_v),
    .wb_ld_gpr1         (wb_ld_gpr1),
    .wb_ld_gpr2         (wb_ld_gpr2),
    .wb_ld_gpr3         (wb_ld_gpr3),
    .wb_dcache_write    (wb_dcache_write),
    .wb_result_a        (wb_result_a),
    .wb_result_b        (wb_result_b),
    .wb_result_c        (wb_result_c),
    .wb_flags           (wb_flags),
    .wb_dr1             (wb_dr1),
    .wb_dr2             (wb_dr2),
    .wb_dr3             (wb_dr3),
    .dep_v_gpr1         (dep_v_gpr1),
    .dep_v_gpr2         (dep_v_gpr2),
    .dep_v_gpr3         (dep_v_gpr3),
    .dep_v_dcache_write (dep_v_dcache_write)
  );

endmodule

// File: src/ex_wb_latch.sv
module ex_wb_latch (
  input  logic             clk,
  input  logic             rst_n,
  input  logic             ex_v,
  input  logic             wb_stall,
  input  logic             wb_repne_terminate,
  input  logic             ld_gpr1,
  input  logic             ld_gpr2,
  input  logic             ld_gpr3,
  input  logic             dcache_write,
  input  ex_pkg::word_t    result_a,
  input  ex_pkg::word_t    result_b,
  input  ex_pkg::word_t    result_c,
  input  ex_pkg::flags_t   flags,
  input  ex_pkg::reg_idx_t dr1,
  input  ex_pkg::reg_idx_t dr2,
  input  ex_pkg::reg_idx_t dr3,
  output logic             wb_ld_latches,
  output logic             wb_v,
  output logic             wb_ld_gpr1,
  output logic             wb_ld_gpr2,
  output logic             wb_ld_gpr3,
  output logic             wb_dcache_write,
  output ex_pkg::word_t    wb_result_a,
  output ex_pkg::word_t    wb_result_b,
  output ex_pkg::word_t    wb_result_c,
  output ex_pkg::flags_t   wb_flags,
  output ex_pkg::reg_idx_t wb_dr1,
  output ex_pkg::reg_idx_t wb_dr2,
  output ex_pkg::reg_idx_t wb_dr3,
  output logic             dep_v_gpr1,
  output logic             dep_v_gpr2,
  output logic             dep_v_gpr3,
  output logic             dep_v_dcache_write
);

  assign wb_ld_latches = ~wb_stall;

  // valid and write enables, bubble when the loop terminates
  always_ff @(posedge clk) begin
    if (!rst_n) begin
      wb_v            <= 1'b0;
      wb_ld_gpr1      <= 1'b0;
      wb_ld_gpr2      <= 1'b0;
      wb_ld_gpr3      <= 1'b0;
      wb_dcache_write <= 1'b0;
    end else if (wb_ld_latches) begin
      wb_v            <= ex_v & ~wb_repne_terminate;
      wb_ld_gpr1      <= ld_gpr1;
      wb_ld_gpr2      <= ld_gpr2;
      wb_ld_gpr3      <= ld_gpr3;
      wb_dcache_write <= dcache_write;
    end
  end

  always_ff @(posedge clk) begin
    if (wb_ld_latches) begin
      wb_result_a <= result_a;
      wb_result_b <= result_b;
      wb_result_c <= result_c;
      wb_flags    <= flags;
      wb_dr1      <= dr1;
      wb_dr2      <= dr2;
      wb_dr3      <= dr3;
    end
  end

  // registers the uop in execute is about to write
  assign dep_v_gpr1         = ex_v & ld_gpr1;
  assign dep_v_gpr2         = ex_v & ld_gpr2;
  assign dep_v_gpr3         = ex_v & ld_gpr3;
  assign dep_v_dcache_write = ex_v & dcache_write;

endmodule

// File: src/ex_result_select.sv
module ex_result_select (
  input  ex_pkg::unit_sel_e unit_sel,
  input  logic              is_cmpxchg,
  input  logic              is_shift,
  input  logic              repne,
  input  logic              ld_gpr1_in,
  input  logic              ld_gpr2_in,
  input  logic              dcache_write_in,
  input  ex_pkg::word_t     a,
  input  ex_pkg::word_t     b,
  input  ex_pkg::word_t     c,
  input  ex_pkg::word_t     count,
  input  ex_pkg::word_t     alu_result,
  input  ex_pkg::word_t     shift_result,
  input  ex_pkg::flags_t    alu_flags,
  input  ex_pkg::flags_t    shift_flags,
  input  ex_pkg::flags_t    flags_fwd,
  output ex_pkg::word_t     result_a,
  output ex_pkg::word_t     result_b,
  output ex_pkg::word_t     result_c,
  output ex_pkg::flags_t    flags,
  output logic              ld_gpr1,
  output logic              ld_gpr2,
  output logic              dcache_write
);
  import ex_pkg::*;

  logic equal;

  // alu ran accumulator minus destination
  assign equal = alu_flags[flag_zf];

  always_comb begin
    if (is_cmpxchg) begin
      // source goes to the destination on a match
      result_a = b;
    end else begin
      case (unit_sel)
        unit_alu:    result_a = alu_result;
        unit_shift:  result_a = shift_result;
        unit_pass_a: result_a = a;
        default:     result_a = b;
      endcase
    end
  end

  // destination value is loaded into the accumulator on a miss
  assign result_b = (unit_sel == unit_xchg || is_cmpxchg) ? a : b;

  assign result_c = repne ? count - 32'd1 : c;

  always_comb begin
    if (is_shift) begin
      flags = shift_flags;
    end else if (unit_sel == unit_alu || is_cmpxchg) begin
      flags = alu_flags;
    end else begin
      flags = flags_fwd;
    end
  end

  // cmpxchg write decision
  always_comb begin
    if (is_cmpxchg) begin
      ld_gpr1      = ld_gpr1_in & equal;
      ld_gpr2      = ~equal;
      dcache_write = dcache_write_in & equal;
    end else begin
      ld_gpr1      = ld_gpr1_in;
      ld_gpr2      = ld_gpr2_in;
      dcache_write = dcache_write_in;
    end
  end

endmodule

// File: src/ex_shifter.sv
module ex_shifter (
  input  ex_pkg::shift_op_e op,
  input  ex_pkg::size_e     size,
  input  ex_pkg::word_t     value,
  input  ex_pkg::word_t     amount,
  input  ex_pkg::flags_t    flags_in,
  output ex_pkg::word_t     result,
  output ex_pkg::flags_t    flags
);
  import ex_pkg::*;

  logic [4:0]         amt;
  word_t              mask;
  word_t              v;
  word_t              sx;
  word_t              res;
  logic [32:0]        shl_wide;
  logic [32:0]        shr_wide;
  logic signed [32:0] sar_wide;
  logic               cf;
  logic               of;

  assign amt  = amount[4:0];
  assign mask = size_mask(size);
  assign v    = value & mask;

  // sign extend from the operand size for sar
  always_comb begin
    case (size)
      size_8:  sx = {{24{v[7]}}, v[7:0]};
      size_16: sx = {{16{v[15]}}, v[15:0]};
      default: sx = v;
    endcase
  end

  // extra bit on each wide shift catches the last bit out
  assign shl_wide = {1'b0, v} << amt;
  assign shr_wide = {v, 1'b0} >> amt;
  assign sar_wide = $signed({sx, 1'b0}) >>> amt;

  always_comb begin
    res = value;
    cf  = 1'b0;
    of  = 1'b0;
    case (op)
      sh_shl: begin
        res = shl_wide[31:0] & mask;
        cf  = shl_wide[size_bits(size)];
        of  = sign_bit(res, size) ^ cf;
      end
      sh_shr: begin
        res = shr_wide[32:1];
        cf  = shr_wide[0];
        of  = sign_bit(v, size);
      end
      sh_sar: begin
        res = sar_wide[32:1] & mask;
        cf  = sar_wide[0];
        of  = 1'b0;
      end
      default: res = value;
    endcase
  end

  always_comb begin
    flags = flags_in;
    if (op != sh_none && amt != 5'd0) begin
      flags[flag_cf] = cf;
      flags[flag_of] = of;
      flags[flag_zf] = (res == '0);
      flags[flag_sf] = sign_bit(res, size);
      flags[flag_pf] = ~^res[7:0];
    end
  end

  // zero count leaves the operand alone
  assign result = (op == sh_none || amt == 5'd0) ? value : res;

endmodule

// File: src/ex_alu32.sv
module ex_alu32 (
  input  ex_pkg::alu_op_e op,
  input  ex_pkg::size_e   size,
  input  ex_pkg::word_t   a,
  input  ex_pkg::word_t   b,
  input  ex_pkg::flags_t  flags_in,
  output ex_pkg::word_t   result,
  output ex_pkg::flags_t  flags
);
  import ex_pkg::*;

  word_t       mask;
  word_t       a_m;
  word_t       b_m;
  word_t       res;
  logic [32:0] wide;
  logic        carry;
  logic        ovf;
  logic        sa;
  logic        sb;
  logic        sr;

  always_comb begin
    mask  = size_mask(size);
    a_m   = a & mask;
    b_m   = b & mask;
    wide  = '0;
    carry = 1'b0;
    ovf   = 1'b0;
    res   = '0;
    sa    = sign_bit(a_m, size);
    sb    = sign_bit(b_m, size);

    case (op)
      alu_add: begin
        wide = {1'b0, a_m} + {1'b0, b_m};
        res  = wide[31:0] & mask;
      end
      alu_sub, alu_cmp: begin
        // borrow shows up as the bit just above the operand width
        wide = {1'b0, a_m} - {1'b0, b_m};
        res  = wide[31:0] & mask;
      end
      alu_and:    res = a_m & b_m;
      alu_or:     res = a_m | b_m;
      alu_xor:    res = a_m ^ b_m;
      alu_not:    res = ~a_m & mask;
      alu_pass_b: res = b_m;
      default:    res = '0;
    endcase

    sr = sign_bit(res, size);

    case (op)
      alu_add: begin
        carry = wide[size_bits(size)];
        ovf   = (sa == sb) && (sr != sa);
      end
      alu_sub, alu_cmp: begin
        carry = wide[size_bits(size)];
        ovf   = (sa != sb) && (sr != sa);
      end
      // logic ops clear cf and of
      default: begin
        carry = 1'b0;
        ovf   = 1'b0;
      end
    endcase
  end

  always_comb begin
    flags = flags_in;
    // not does not touch any flag
    if (op != alu_not) begin
      flags[flag_cf] = carry;
      flags[flag_of] = ovf;
      flags[flag_zf] = (res == '0);
      flags[flag_sf] = sr;
      flags[flag_pf] = ~^res[7:0];
    end
  end

  assign result = res;

endmodule

// File: src/ex_operand_select.sv
module ex_operand_select (
  input  logic          clk,
  input  logic          rst_n,
  input  logic          ld,
  input  logic          ex_v,
  input  logic          is_cmps_first,
  input  logic          is_cmps_second,
  input  logic          repne_steady,
  input  logic          repne,
  input  ex_pkg::word_t a,
  input  ex_pkg::word_t b,
  input  ex_pkg::word_t count_fwd,
  output ex_pkg::word_t b_eff,
  output ex_pkg::word_t count
);
  import ex_pkg::*;

  word_t cmps_a_q;
  word_t count_q;

  // first string operand and running loop count
  always_ff @(posedge clk) begin
    if (!rst_n) begin
      cmps_a_q <= '0;
      count_q  <= '0;
    end else if (ld && ex_v) begin
      if (is_cmps_first) begin
        cmps_a_q <= a;
      end
      if (repne) begin
        count_q <= count - 32'd1;
      end
    end
  end

  // second cmps uop compares against the saved first operand
  assign b_eff = is_cmps_second ? cmps_a_q : b;

  // forwarded count only until the loop is in steady state
  assign count = repne_steady ? count_q : count_fwd;

endmodule

// File: src/ex_pkg.sv
package ex_pkg;

  typedef logic [31:0] word_t;
  typedef logic [31:0] flags_t;
  typedef logic [2:0]  reg_idx_t;

  // EFLAGS bit positions
  localparam int flag_cf = 0;
  localparam int flag_pf = 2;
  localparam int flag_zf = 6;
  localparam int flag_sf = 7;
  localparam int flag_of = 11;

  typedef enum logic [1:0] {
    size_8  = 2'd0,
    size_16 = 2'd1,
    size_32 = 2'd2
  } size_e;

  typedef enum logic [2:0] {
    alu_add    = 3'd0,
    alu_sub    = 3'd1,
    alu_and    = 3'd2,
    alu_or     = 3'd3,
    alu_xor    = 3'd4,
    alu_not    = 3'd5,
    alu_pass_b = 3'd6,
    alu_cmp    = 3'd7
  } alu_op_e;

  typedef enum logic [1:0] {
    sh_none = 2'd0,
    sh_shl  = 2'd1,
    sh_shr  = 2'd2,
    sh_sar  = 2'd3
  } shift_op_e;

  // source of result A
  typedef enum logic [1:0] {
    unit_alu    = 2'd0,
    unit_shift  = 2'd1,
    unit_pass_a = 2'd2,
    unit_xchg   = 2'd3
  } unit_sel_e;

  // operand width in bits, unused encoding acts as 32
  function automatic int size_bits(size_e size);
    case (size)
      size_8:  return 8;
      size_16: return 16;
      default: return 32;
    endcase
  endfunction

  function automatic word_t size_mask(size_e size);
    case (size)
      size_8:  return 32'h0000_00ff;
      size_16: return 32'h0000_ffff;
      default: return 32'hffff_ffff;
    endcase
  endfunction

  function automatic logic sign_bit(word_t value, size_e size);
    return value[size_bits(size) - 1];
  endfunction

endpackage
